/* project.f */
verilog/tcb_pkg.sv
verilog/soc_pkg.sv
verilog/tcb_decoder_demux.sv
verilog/tcb_size_to_byteena.sv
verilog/tcb_register_request.sv
verilog/soc_memory.sv
verilog/tcb_gpio.sv
verilog/tcb_soc_top.sv
testbench/tcb_soc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the soc testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tcb_soc_tb -f project.f -o tcb_soc_sim

# a failing run still leaves its log for the search below
./obj_dir/tcb_soc_sim 2>&1 | tee sim.log || true

if grep -q "^TESTS PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* testbench/tcb_soc_tb.sv */
`timescale 1ns/10ps

module tcb_soc_tb;

    ////////////////////////////////////////////////////////////
    // run length
    ////////////////////////////////////////////////////////////

    localparam int clk_period = 4;
    localparam int rst_cycles = 4;
    // random word writes followed by as many reads
    localparam int n_rand = 48;
    // transfer count of all tests with margin
    localparam int xfer_budget = 2 * n_rand + 200;
    // four cycles allowed per transfer
    localparam int timeout_ns = (rst_cycles + 4 * xfer_budget) * clk_period;
    // memory window size in bytes
    localparam int unsigned mem_bytes = 4 * (2 ** soc_pkg::mem_adr_w);
    // gpio half of the peripheral window
    localparam logic [31:0] gpio_span = 32'h40;
    localparam logic [31:0] gpio_base = soc_pkg::per_base;
    localparam logic [31:0] uart_base = soc_pkg::per_base + 32'h40;

    // expected response and whether rdt is predicted
    typedef struct packed {
        logic              chk_rdt;
        tcb_pkg::tcb_rsp_t rsp;
    } exp_t;

    logic clk;
    logic rst;
    logic vld;
    tcb_pkg::tcb_req_t req;
    logic rdy;
    tcb_pkg::tcb_rsp_t rsp;
    logic [31:0] gpio_drive;
    logic [31:0] gpio_enable;
    logic [31:0] gpio_pins;

    // reference model state
    logic [7:0] mem_model [0:mem_bytes-1];
    logic [31:0] drv_now;
    logic [31:0] ena_now;
    // lagging copies as seen on the pins
    logic [31:0] drv_vis;
    logic [31:0] ena_vis;
    logic pend;
    exp_t exp_q;
    int exp_tid;
    int cur_tid;
    logic [31:0] lfsr;
    logic [31:0] adr_q [$];

    tcb_soc_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .vld         (vld),
        .req         (req),
        .rdy         (rdy),
        .rsp         (rsp),
        .gpio_drive  (gpio_drive),
        .gpio_enable (gpio_enable),
        .gpio_pins   (gpio_pins)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic string test_name(input int id);
        case (id)
            1:       return "word_rw";
            2:       return "byte_half";
            3:       return "misaligned";
            4:       return "gpio";
            5:       return "error_rsp";
            6:       return "interleave";
            default: return "reset";
        endcase
    endfunction

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // one transfer held until rdy and accepted at the next edge
    task automatic xfer(input logic wen, input logic [31:0] adr,
                        input tcb_pkg::tcb_siz_e siz, input logic [31:0] wdt);
        vld = 1'b1;
        req.wen = wen;
        req.adr = adr;
        req.siz = siz;
        req.wdt = wdt;
        #1;
        while (!rdy) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #1;
        vld = 1'b0;
    endtask

    task automatic idle();
        vld = 1'b0;
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic exp_t predict(input tcb_pkg::tcb_req_t r);
        exp_t e;
        int unsigned nb;
        logic [31:0] ofs;
        e.chk_rdt = 1'b1;
        e.rsp = '0;
        nb = 1 << r.siz;
        if (r.adr - soc_pkg::mem_base < mem_bytes) begin
            ofs = r.adr - soc_pkg::mem_base;
            if (ofs % nb != 0) begin
                // misaligned access leaves memory alone
                e.rsp.err = 1'b1;
            end else if (r.wen) begin
                for (int i = 0; i < nb; i++) begin
                    mem_model[ofs + i] = r.wdt[8*i +: 8];
                end
                // rdt of a memory write is don't care
                e.chk_rdt = 1'b0;
            end else begin
                for (int i = 0; i < nb; i++) begin
                    e.rsp.rdt[8*i +: 8] = mem_model[ofs + i];
                end
            end
        end else if (r.adr - gpio_base < gpio_span) begin
            ofs = r.adr - gpio_base;
            if (r.siz != tcb_pkg::siz_word) begin
                e.rsp.err = 1'b1;
            end else if (ofs == 32'h00) begin
                if (r.wen) begin
                    drv_now = r.wdt;
                end else begin
                    e.rsp.rdt = drv_now;
                end
            end else if (ofs == 32'h04) begin
                if (r.wen) begin
                    ena_now = r.wdt;
                end else begin
                    e.rsp.rdt = ena_now;
                end
            end else if (ofs == 32'h08 && !r.wen) begin
                e.rsp.rdt = gpio_pins;
            end else begin
                // unknown offset or pin write
                e.rsp.err = 1'b1;
            end
        end else begin
            // uart slot and unmapped space
            e.rsp.err = 1'b1;
        end
        return e;
    endfunction

    always @(posedge clk) begin
        exp_t e;
        if (rst) begin
            drv_now = '0;
            ena_now = '0;
            drv_vis <= '0;
            ena_vis <= '0;
            pend <= 1'b0;
        end else begin
            // gpio registers update one cycle after the handshake
            drv_vis <= drv_now;
            ena_vis <= ena_now;
            if (vld && rdy) begin
                e = predict(req);
                exp_q <= e;
                exp_tid <= cur_tid;
                pend <= 1'b1;
            end else begin
                pend <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // assertions
    ////////////////////////////////////////////////////////////

    rsp_check: assert property (@(posedge clk) disable iff (rst)
        pend |-> (rsp.err == exp_q.rsp.err && (!exp_q.chk_rdt || rsp.rdt == exp_q.rsp.rdt)))
    else begin
        $display("Error: %s rsp expected %h actual %h", test_name($sampled(exp_tid)),
                 $sampled(exp_q.rsp), $sampled(rsp));
        abort_run();
    end

    rdy_check: assert property (@(posedge clk) disable iff (rst) rdy)
    else begin
        $display("manager port dropped rdy during %s", test_name($sampled(cur_tid)));
        abort_run();
    end

    drive_check: assert property (@(posedge clk) disable iff (rst) gpio_drive == drv_vis)
    else begin
        $display("Error: %s gpio_drive expected %h actual %h", test_name($sampled(cur_tid)),
                 $sampled(drv_vis), $sampled(gpio_drive));
        abort_run();
    end

    enable_check: assert property (@(posedge clk) disable iff (rst) gpio_enable == ena_vis)
    else begin
        $display("Error: %s gpio_enable expected %h actual %h", test_name($sampled(cur_tid)),
                 $sampled(ena_vis), $sampled(gpio_enable));
        abort_run();
    end

    // watchdog
    initial begin
        #(timeout_ns);
        $display("watchdog expired before the tests finished");
        abort_run();
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] a;
        lfsr = 32'd5023;
        rst = 1'b1;
        vld = 1'b0;
        req = '0;
        gpio_pins = '0;
        cur_tid = 0;
        repeat (rst_cycles) @(posedge clk);
        #1;
        rst = 1'b0;

        // back to back word writes and their reads
        cur_tid = 1;
        for (int i = 0; i < n_rand; i++) begin
            a = soc_pkg::mem_base | (rand_bits(12) << 2);
            adr_q.push_back(a);
            xfer(1'b1, a, tcb_pkg::siz_word, rand_bits(32));
        end
        foreach (adr_q[i]) xfer(1'b0, adr_q[i], tcb_pkg::siz_word, '0);

        // sub-word merges with junk in the upper wdt bits
        cur_tid = 2;
        repeat (4) begin
            a = soc_pkg::mem_base | (rand_bits(12) << 2);
            xfer(1'b1, a, tcb_pkg::siz_word, rand_bits(32));
            xfer(1'b1, a + 1, tcb_pkg::siz_byte, rand_bits(32));
            xfer(1'b1, a + 2, tcb_pkg::siz_half, rand_bits(32));
            for (int k = 0; k < 4; k++) xfer(1'b0, a + k, tcb_pkg::siz_byte, '0);
            xfer(1'b0, a, tcb_pkg::siz_half, '0);
            xfer(1'b0, a + 2, tcb_pkg::siz_half, '0);
            xfer(1'b0, a, tcb_pkg::siz_word, '0);
        end

        cur_tid = 3;
        a = adr_q[0];
        xfer(1'b1, a + 1, tcb_pkg::siz_half, rand_bits(32));
        xfer(1'b1, a + 2, tcb_pkg::siz_word, rand_bits(32));
        xfer(1'b1, a + 3, tcb_pkg::siz_word, rand_bits(32));
        xfer(1'b1, a + 3, tcb_pkg::siz_half, rand_bits(32));
        xfer(1'b0, a + 1, tcb_pkg::siz_half, '0);
        xfer(1'b0, a + 2, tcb_pkg::siz_word, '0);
        // word must be unchanged
        xfer(1'b0, a, tcb_pkg::siz_word, '0);

        cur_tid = 4;
        repeat (3) begin
            xfer(1'b1, gpio_base, tcb_pkg::siz_word, rand_bits(32));
            xfer(1'b1, gpio_base + 4, tcb_pkg::siz_word, rand_bits(32));
            xfer(1'b0, gpio_base, tcb_pkg::siz_word, '0);
            xfer(1'b0, gpio_base + 4, tcb_pkg::siz_word, '0);
            // pins need the synchronizer delay
            gpio_pins = rand_bits(32);
            repeat (3) idle();
            xfer(1'b0, gpio_base + 8, tcb_pkg::siz_word, '0);
        end
        xfer(1'b1, gpio_base + 32'h0c, tcb_pkg::siz_word, rand_bits(32));
        xfer(1'b0, gpio_base + 32'h10, tcb_pkg::siz_word, '0);
        xfer(1'b0, gpio_base, tcb_pkg::siz_byte, '0);
        xfer(1'b1, gpio_base + 4, tcb_pkg::siz_half, rand_bits(32));
        xfer(1'b1, gpio_base + 8, tcb_pkg::siz_word, rand_bits(32));
        xfer(1'b0, gpio_base + 1, tcb_pkg::siz_word, '0);
        xfer(1'b0, gpio_base, tcb_pkg::siz_word, '0);
        xfer(1'b0, gpio_base + 4, tcb_pkg::siz_word, '0);

        // uart slot and space outside both windows
        cur_tid = 5;
        xfer(1'b0, uart_base, tcb_pkg::siz_word, '0);
        xfer(1'b1, uart_base + 32'h3c, tcb_pkg::siz_word, rand_bits(32));
        xfer(1'b0, uart_base + 4, tcb_pkg::siz_byte, '0);
        xfer(1'b0, 32'h0000_1000, tcb_pkg::siz_word, '0);
        xfer(1'b1, 32'h8000_8000, tcb_pkg::siz_word, rand_bits(32));
        xfer(1'b0, 32'hffff_fffc, tcb_pkg::siz_word, '0);
        repeat (4) xfer(1'b0, rand_bits(32) & 32'h7fff_fffc, tcb_pkg::siz_word, '0);

        // targets mixed cycle by cycle
        cur_tid = 6;
        a = adr_q[1];
        xfer(1'b1, a, tcb_pkg::siz_word, rand_bits(32));
        xfer(1'b0, gpio_base, tcb_pkg::siz_word, '0);
        xfer(1'b0, uart_base, tcb_pkg::siz_word, '0);
        xfer(1'b0, a, tcb_pkg::siz_word, '0);
        xfer(1'b1, gpio_base, tcb_pkg::siz_word, rand_bits(32));
        xfer(1'b0, a + 1, tcb_pkg::siz_byte, '0);
        xfer(1'b0, gpio_base, tcb_pkg::siz_word, '0);
        xfer(1'b0, 32'h0000_1000, tcb_pkg::siz_word, '0);
        xfer(1'b0, a + 2, tcb_pkg::siz_half, '0);

        // drain the last response
        repeat (3) idle();
        $display("TESTS PASSED");
        $finish;
    end

endmodule: tcb_soc_tb

/* verilog/soc_memory.sv */
`timescale 1ns/10ps

module soc_memory (
    input  logic                     clk,
    // byte enable request
    input  logic                     vld,
    input  tcb_pkg::tcb_ben_req_t     req,
    output logic [tcb_pkg::xlen-1:0] rdt
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    logic [tcb_pkg::xlen-1:0] mem [0:2**soc_pkg::mem_adr_w-1];
    logic [soc_pkg::mem_adr_w-1:0] adr;

    // word index inside the window
    assign adr = req.adr[soc_pkg::mem_adr_w-1:0];

    // write enabled bytes only
    always_ff @(posedge clk) begin
        if (vld && req.wen) begin
            for (int i = 0; i < tcb_pkg::blen; i++) begin
                if (req.ben[i]) begin
                    mem[adr][8*i +: 8] <= req.wdt[8*i +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////

    // one cycle latency, old data on a write
    always_ff @(posedge clk) begin
        if (vld) begin
            rdt <= mem[adr];
        end
    end

endmodule: soc_memory

/* verilog/soc_pkg.sv */
package soc_pkg;

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////

    // shared memory window, 16 KiB
    localparam logic [tcb_pkg::xlen-1:0] mem_base = 32'h8000_0000;
    localparam int unsigned mem_adr_w = 12;
    // byte address bits covered by the memory
    localparam int unsigned mem_span_w = mem_adr_w + 2;

    // peripheral window, gpio in the lower half, uart slot above
    localparam logic [tcb_pkg::xlen-1:0] per_base = 32'h8000_4000;
    localparam int unsigned per_span = 32'h80;
    localparam int unsigned per_ofs_w = $clog2(per_span);

    ////////////////////////////////////////////////////////////
    // gpio
    ////////////////////////////////////////////////////////////

    localparam int unsigned gpio_w = 32;
    localparam logic [per_ofs_w-1:0] gpio_ofs_drive = 7'h00;
    localparam logic [per_ofs_w-1:0] gpio_ofs_enable = 7'h04;
    localparam logic [per_ofs_w-1:0] gpio_ofs_pins = 7'h08;

    // decoder targets
    typedef enum logic [1:0] {
        sel_mem,
        sel_per,
        sel_err
    } tcb_sel_e;

endpackage: soc_pkg

/* verilog/tcb_decoder_demux.sv */
`timescale 1ns/10ps

module tcb_decoder_demux (
    input  logic             clk,
    input  logic             rst,
    // manager side
    input  logic             vld,
    input  tcb_pkg::tcb_req_t req,
    output logic             rdy,
    output tcb_pkg::tcb_rsp_t rsp,
    // memory target
    output logic             mem_vld,
    output tcb_pkg::tcb_req_t mem_req,
    input  logic             mem_rdy,
    input  tcb_pkg::tcb_rsp_t mem_rsp,
    // peripheral target
    output logic             per_vld,
    output tcb_pkg::tcb_req_t per_req,
    input  logic             per_rdy,
    input  tcb_pkg::tcb_rsp_t per_rsp
);

    ////////////////////////////////////////////////////////////
    // address decoding
    ////////////////////////////////////////////////////////////

    soc_pkg::tcb_sel_e sel;
    // selection stored for the response cycle
    soc_pkg::tcb_sel_e sel_q;
    logic mem_hit;
    logic per_hit;

    // upper address bits against each window base
    assign mem_hit = req.adr[tcb_pkg::xlen-1:soc_pkg::mem_span_w]
                  == soc_pkg::mem_base[tcb_pkg::xlen-1:soc_pkg::mem_span_w];
    assign per_hit = req.adr[tcb_pkg::xlen-1:soc_pkg::per_ofs_w]
                  == soc_pkg::per_base[tcb_pkg::xlen-1:soc_pkg::per_ofs_w];

    always_comb begin
        if (mem_hit) begin
            sel = soc_pkg::sel_mem;
        end else if (per_hit && !req.adr[soc_pkg::per_ofs_w-1]) begin
            // lower half of the window is gpio
            sel = soc_pkg::sel_per;
        end else begin
            // uart slot and unmapped space
            sel = soc_pkg::sel_err;
        end
    end

    ////////////////////////////////////////////////////////////
    // request path
    ////////////////////////////////////////////////////////////

    // request broadcast, only the strobe is routed
    assign mem_req = req;
    assign per_req = req;
    assign mem_vld = vld && (sel == soc_pkg::sel_mem);
    assign per_vld = vld && (sel == soc_pkg::sel_per);

    // readiness of the addressed target
    always_comb begin
        case (sel)
            soc_pkg::sel_mem: rdy = mem_rdy;
            soc_pkg::sel_per: rdy = per_rdy;
            default:          rdy = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // response path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            // nothing pending
            sel_q <= soc_pkg::sel_err;
        end else if (vld && rdy) begin
            sel_q <= sel;
        end
    end

    always_comb begin
        case (sel_q)
            soc_pkg::sel_mem: rsp = mem_rsp;
            soc_pkg::sel_per: rsp = per_rsp;
            default: begin
                // error responder
                rsp.rdt = '0;
                rsp.err = 1'b1;
            end
        endcase
    end

endmodule: tcb_decoder_demux

/* verilog/tcb_gpio.sv */
`timescale 1ns/10ps

module tcb_gpio (
    input  logic                       clk,
    input  logic                       rst,
    // zero-delay bus
    input  logic                       vld,
    input  tcb_pkg::tcb_req_t           req,
    output logic                       rdy,
    output tcb_pkg::tcb_rsp_t           rsp,
    // pins
    output logic [soc_pkg::gpio_w-1:0] gpio_drive,
    output logic [soc_pkg::gpio_w-1:0] gpio_enable,
    input  logic [soc_pkg::gpio_w-1:0] gpio_pins
);

    logic [soc_pkg::per_ofs_w-1:0] ofs;
    logic ok;
    logic [soc_pkg::gpio_w-1:0] pins_meta;
    logic [soc_pkg::gpio_w-1:0] pins_sync;
    logic [tcb_pkg::xlen-1:0] rd;

    assign rdy = 1'b1;
    assign ofs = req.adr[soc_pkg::per_ofs_w-1:0];

    ////////////////////////////////////////////////////////////
    // access check
    ////////////////////////////////////////////////////////////

    // word access to a known register, pins are read only
    assign ok = (req.siz == tcb_pkg::siz_word)
             && ((ofs == soc_pkg::gpio_ofs_drive)
              || (ofs == soc_pkg::gpio_ofs_enable)
              || ((ofs == soc_pkg::gpio_ofs_pins) && !req.wen));

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_drive  <= '0;
            gpio_enable <= '0;
        end else if (vld && req.wen && ok) begin
            if (ofs == soc_pkg::gpio_ofs_drive) begin
                gpio_drive <= req.wdt[soc_pkg::gpio_w-1:0];
            end else begin
                gpio_enable <= req.wdt[soc_pkg::gpio_w-1:0];
            end
        end
    end

    // two flop input synchronizer
    always_ff @(posedge clk) begin
        pins_meta <= gpio_pins;
        pins_sync <= pins_meta;
    end

    ////////////////////////////////////////////////////////////
    // read data
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd = '0;
        case (ofs)
            soc_pkg::gpio_ofs_drive:  rd[soc_pkg::gpio_w-1:0] = gpio_drive;
            soc_pkg::gpio_ofs_enable: rd[soc_pkg::gpio_w-1:0] = gpio_enable;
            default:                  rd[soc_pkg::gpio_w-1:0] = pins_sync;
        endcase
    end

    // zero on errors and on writes
    assign rsp.rdt = (ok && !req.wen) ? rd : '0;
    assign rsp.err = !ok;

endmodule: tcb_gpio

/* verilog/tcb_pkg.sv */
package tcb_pkg;

    ////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////

    // data and byte address width
    localparam int unsigned xlen = 32;
    // byte lanes per data word
    localparam int unsigned blen = xlen / 8;

    ////////////////////////////////////////////////////////////
    // transfer size
    ////////////////////////////////////////////////////////////

    // log2 of the transfer size in bytes
    typedef enum logic [1:0] {
        siz_byte = 2'd0,
        siz_half = 2'd1,
        siz_word = 2'd2
    } tcb_siz_e;

    ////////////////////////////////////////////////////////////
    // request and response
    ////////////////////////////////////////////////////////////

    // size coded request, write data right aligned
    typedef struct packed {
        logic            wen;
        logic [xlen-1:0] adr;
        tcb_siz_e        siz;
        logic [xlen-1:0] wdt;
    } tcb_req_t;

    // response, valid one cycle after the handshake
    typedef struct packed {
        logic [xlen-1:0] rdt;
        logic            err;
    } tcb_rsp_t;

    // byte enable request, word address and data in its lanes
    typedef struct packed {
        logic            wen;
        logic [xlen-3:0] adr;
        logic [blen-1:0] ben;
        logic [xlen-1:0] wdt;
    } tcb_ben_req_t;

endpackage: tcb_pkg

/* verilog/tcb_register_request.sv */
`timescale 1ns/10ps

module tcb_register_request (
    input  logic             clk,
    input  logic             rst,
    // one-delay side
    input  logic             vld,
    input  tcb_pkg::tcb_req_t req,
    output logic             rdy,
    output tcb_pkg::tcb_rsp_t rsp,
    // zero-delay peripheral side
    output logic             per_vld,
    output tcb_pkg::tcb_req_t per_req,
    input  logic             per_rdy,
    input  tcb_pkg::tcb_rsp_t per_rsp
);

    ////////////////////////////////////////////////////////////
    // holding register
    ////////////////////////////////////////////////////////////

    logic full;
    tcb_pkg::tcb_req_t req_q;

    // room when empty or when the entry drains this cycle
    assign rdy = !full || per_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (vld && rdy) begin
            full <= 1'b1;
        end else if (per_rdy) begin
            // entry consumed, nothing new
            full <= 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (vld && rdy) begin
            req_q <= req;
        end
    end

    ////////////////////////////////////////////////////////////
    // peripheral side
    ////////////////////////////////////////////////////////////

    // entry presented the cycle after capture
    assign per_vld = full;
    assign per_req = req_q;

    // zero-delay answer lines up with the one-delay response slot
    assign rsp = per_rsp;

endmodule: tcb_register_request

/* verilog/tcb_size_to_byteena.sv */
`timescale 1ns/10ps

module tcb_size_to_byteena (
    input  logic                 clk,
    input  logic                 rst,
    // size coded side
    input  logic                 vld,
    input  tcb_pkg::tcb_req_t     req,
    output logic                 rdy,
    output tcb_pkg::tcb_rsp_t     rsp,
    // byte enable side
    output logic                 mem_vld,
    output tcb_pkg::tcb_ben_req_t mem_req,
    input  logic [tcb_pkg::xlen-1:0] mem_rdt
);

    logic [1:0] ofs;
    logic mis;
    // captured at the handshake
    logic [1:0] ofs_q;
    tcb_pkg::tcb_siz_e siz_q;
    logic mis_q;
    logic [tcb_pkg::xlen-1:0] rdt_sh;

    // memory never stalls
    assign rdy = 1'b1;
    assign ofs = req.adr[1:0];

    ////////////////////////////////////////////////////////////
    // request conversion
    ////////////////////////////////////////////////////////////

    always_comb begin
        mem_req.wen = req.wen;
        mem_req.adr = req.adr[tcb_pkg::xlen-1:2];
        // data moved into its byte lanes
        mem_req.wdt = req.wdt << {ofs, 3'b000};
        case (req.siz)
            tcb_pkg::siz_byte: mem_req.ben = 4'b0001 << ofs;
            tcb_pkg::siz_half: mem_req.ben = 4'b0011 << ofs;
            default:           mem_req.ben = 4'b1111;
        endcase
    end

    // half at odd address, word off alignment
    assign mis = ((req.siz == tcb_pkg::siz_half) && ofs[0])
              || ((req.siz == tcb_pkg::siz_word) && (ofs != 2'b00));
    // misaligned access never reaches memory
    assign mem_vld = vld && !mis;

    ////////////////////////////////////////////////////////////
    // response realignment
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mis_q <= 1'b0;
        end else if (vld && rdy) begin
            mis_q <= mis;
        end
    end

    always_ff @(posedge clk) begin
        if (vld && rdy) begin
            ofs_q <= ofs;
            siz_q <= req.siz;
        end
    end

    // lanes down to bit 0
    assign rdt_sh = mem_rdt >> {ofs_q, 3'b000};

    always_comb begin
        rsp.err = mis_q;
        if (mis_q) begin
            rsp.rdt = '0;
        end else begin
            case (siz_q)
                tcb_pkg::siz_byte: rsp.rdt = {24'd0, rdt_sh[7:0]};
                tcb_pkg::siz_half: rsp.rdt = {16'd0, rdt_sh[15:0]};
                default:           rsp.rdt = rdt_sh;
            endcase
        end
    end

endmodule: tcb_size_to_byteena

/* verilog/tcb_soc_top.sv */
`timescale 1ns/10ps

module tcb_soc_top (
    input  logic                       clk,
    input  logic                       rst,
    // manager port
    input  logic                       vld,
    input  tcb_pkg::tcb_req_t           req,
    output logic                       rdy,
    output tcb_pkg::tcb_rsp_t           rsp,
    // gpio pins
    output logic [soc_pkg::gpio_w-1:0] gpio_drive,
    output logic [soc_pkg::gpio_w-1:0] gpio_enable,
    input  logic [soc_pkg::gpio_w-1:0] gpio_pins
);

    // demux outputs
    logic dmx_mem_vld, dmx_mem_rdy;
    logic dmx_per_vld, dmx_per_rdy;
    tcb_pkg::tcb_req_t dmx_mem_req, dmx_per_req;
    tcb_pkg::tcb_rsp_t dmx_mem_rsp, dmx_per_rsp;
    // memory bus, one delay
    logic mem_vld;
    tcb_pkg::tcb_ben_req_t mem_req;
    logic [tcb_pkg::xlen-1:0] mem_rdt;
    // peripheral bus, zero delay
    logic pb0_vld, pb0_rdy;
    tcb_pkg::tcb_req_t pb0_req;
    tcb_pkg::tcb_rsp_t pb0_rsp;

    ////////////////////////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////////////////////////

    tcb_decoder_demux dec (
        .clk (clk), .rst (rst),
        .vld (vld), .req (req), .rdy (rdy), .rsp (rsp),
        .mem_vld (dmx_mem_vld), .mem_req (dmx_mem_req),
        .mem_rdy (dmx_mem_rdy), .mem_rsp (dmx_mem_rsp),
        .per_vld (dmx_per_vld), .per_req (dmx_per_req),
        .per_rdy (dmx_per_rdy), .per_rsp (dmx_per_rsp)
    );

    // size coded to byte enables for the memory
    tcb_size_to_byteena mem_cnv (
        .clk (clk), .rst (rst),
        .vld (dmx_mem_vld), .req (dmx_mem_req), .rdy (dmx_mem_rdy), .rsp (dmx_mem_rsp),
        .mem_vld (mem_vld), .mem_req (mem_req), .mem_rdt (mem_rdt)
    );

    soc_memory mem (.clk (clk), .vld (mem_vld), .req (mem_req), .rdt (mem_rdt));

    ////////////////////////////////////////////////////////////
    // peripherals
    ////////////////////////////////////////////////////////////

    // register stage in front of the zero-delay bus
    tcb_register_request per_reg (
        .clk (clk), .rst (rst),
        .vld (dmx_per_vld), .req (dmx_per_req), .rdy (dmx_per_rdy), .rsp (dmx_per_rsp),
        .per_vld (pb0_vld), .per_req (pb0_req), .per_rdy (pb0_rdy), .per_rsp (pb0_rsp)
    );

    tcb_gpio gpio (
        .clk (clk), .rst (rst),
        .vld (pb0_vld), .req (pb0_req), .rdy (pb0_rdy), .rsp (pb0_rsp),
        .gpio_drive (gpio_drive), .gpio_enable (gpio_enable), .gpio_pins (gpio_pins)
    );

endmodule: tcb_soc_top
